// ==== axi_pkg.sv ====
`default_nettype none

// widths and response codes shared by every AXI link in the fabric.
package axi_pkg;

	typedef logic [31:0] addr_t; // byte address, one word.
	typedef logic [63:0] data_t; // one beat, two words.
	typedef logic [7:0] strb_t; // one bit per byte of data_t.
	typedef logic [3:0] id_t;
	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

	// timer window, everything outside it goes to the sram.
	localparam axi_pkg::addr_t clint_base = 32'h0200_0000;
	localparam axi_pkg::addr_t clint_limit = 32'h0200_ffff;

	localparam int sram_words = 256; // 64-bit words.

	// which master owns the fabric, and where its request goes.
	typedef enum logic [2:0] {
		grant_idle,
		grant_fetch,
		grant_clint,
		grant_data_read,
		grant_data_write
	} grant_t;

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  logic clock,
	input  logic reset,

	input  logic fetch_arvalid,
	input  axi_pkg::addr_t fetch_araddr,
	input  axi_pkg::id_t fetch_arid,
	output logic fetch_arready,
	output logic fetch_rvalid,
	output axi_pkg::data_t fetch_rdata,
	output axi_pkg::resp_t fetch_rresp,
	output axi_pkg::id_t fetch_rid,
	output logic fetch_rlast,
	input  logic fetch_rready,

	input  logic data_arvalid,
	input  axi_pkg::addr_t data_araddr,
	input  axi_pkg::id_t data_arid,
	output logic data_arready,
	output logic data_rvalid,
	output axi_pkg::data_t data_rdata,
	output axi_pkg::resp_t data_rresp,
	output axi_pkg::id_t data_rid,
	output logic data_rlast,
	input  logic data_rready,
	input  logic data_awvalid,
	input  axi_pkg::addr_t data_awaddr,
	input  axi_pkg::id_t data_awid,
	output logic data_awready,
	input  logic data_wvalid,
	input  axi_pkg::data_t data_wdata,
	input  axi_pkg::strb_t data_wstrb,
	output logic data_wready,
	output logic data_bvalid,
	output axi_pkg::resp_t data_bresp,
	output axi_pkg::id_t data_bid,
	input  logic data_bready,

	output logic mem_arvalid,
	output axi_pkg::addr_t mem_araddr,
	output axi_pkg::id_t mem_arid,
	input  logic mem_arready,
	input  logic mem_rvalid,
	input  axi_pkg::data_t mem_rdata,
	input  axi_pkg::resp_t mem_rresp,
	input  axi_pkg::id_t mem_rid,
	input  logic mem_rlast,
	output logic mem_rready,
	output logic mem_awvalid,
	output axi_pkg::addr_t mem_awaddr,
	output axi_pkg::id_t mem_awid,
	input  logic mem_awready,
	output logic mem_wvalid,
	output axi_pkg::data_t mem_wdata,
	output axi_pkg::strb_t mem_wstrb,
	input  logic mem_wready,
	input  logic mem_bvalid,
	input  axi_pkg::resp_t mem_bresp,
	input  axi_pkg::id_t mem_bid,
	output logic mem_bready,

	output logic clint_arvalid,
	output axi_pkg::addr_t clint_araddr,
	output axi_pkg::id_t clint_arid,
	input  logic clint_arready,
	input  logic clint_rvalid,
	input  axi_pkg::data_t clint_rdata,
	input  axi_pkg::resp_t clint_rresp,
	input  axi_pkg::id_t clint_rid,
	output logic clint_rready
);
	import axi_pkg::*;
	import soc_map_pkg::*;

	grant_t grant;
	logic clint_write; // held write targets the timer window.
	logic local_bvalid;
	id_t local_bid;
	logic local_accept;
	logic txn_done;
	logic read_in_clint;
	logic write_in_clint;

	assign read_in_clint = (data_araddr >= clint_base) && (data_araddr <= clint_limit);
	assign write_in_clint = (data_awaddr >= clint_base) && (data_awaddr <= clint_limit);

	always_ff @(posedge clock) begin
		if (reset) begin
			grant <= grant_idle;
			clint_write <= 1'b0;
		end else if (grant == grant_idle) begin
			if (fetch_arvalid) begin
				grant <= grant_fetch;
			end else if (data_arvalid) begin
				grant <= read_in_clint ? grant_clint : grant_data_read;
			end else if (data_awvalid) begin
				grant <= grant_data_write;
				clint_write <= write_in_clint;
			end
		end else if (txn_done) begin
			grant <= grant_idle; // idle for one cycle after the last response.
		end
	end

	// the timer has no write port, so such writes end here with slverr.
	assign local_accept = (grant == grant_data_write) && clint_write && data_awvalid
		&& data_wvalid && !local_bvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			local_bvalid <= 1'b0;
		end else if (local_accept) begin
			local_bvalid <= 1'b1;
		end else if (data_bready) begin
			local_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (local_accept)
			local_bid <= data_awid;
	end

	always_comb begin
		case (grant)
			grant_fetch: txn_done = fetch_rvalid && fetch_rready && fetch_rlast;
			grant_clint, grant_data_read: txn_done = data_rvalid && data_rready && data_rlast;
			grant_data_write: txn_done = data_bvalid && data_bready;
			default: txn_done = 1'b0;
		endcase
	end

	// payload is steered freely, only the valids and readies follow the grant.
	assign mem_araddr = (grant == grant_fetch) ? fetch_araddr : data_araddr;
	assign mem_arid = (grant == grant_fetch) ? fetch_arid : data_arid;
	assign mem_awaddr = data_awaddr;
	assign mem_awid = data_awid;
	assign mem_wdata = data_wdata;
	assign mem_wstrb = data_wstrb;
	assign clint_araddr = data_araddr;
	assign clint_arid = data_arid;

	assign fetch_rdata = mem_rdata;
	assign fetch_rresp = mem_rresp;
	assign fetch_rid = mem_rid;
	assign fetch_rlast = mem_rlast;
	assign data_rdata = (grant == grant_clint) ? clint_rdata : mem_rdata;
	assign data_rresp = (grant == grant_clint) ? clint_rresp : mem_rresp;
	assign data_rid = (grant == grant_clint) ? clint_rid : mem_rid;
	assign data_rlast = (grant == grant_clint) ? 1'b1 : mem_rlast; // timer reads are one beat.
	assign data_bresp = clint_write ? resp_slverr : mem_bresp;
	assign data_bid = clint_write ? local_bid : mem_bid;

	always_comb begin
		fetch_arready = 1'b0;
		fetch_rvalid = 1'b0;
		data_arready = 1'b0;
		data_rvalid = 1'b0;
		data_awready = 1'b0;
		data_wready = 1'b0;
		data_bvalid = 1'b0;
		mem_arvalid = 1'b0;
		mem_rready = 1'b0;
		mem_awvalid = 1'b0;
		mem_wvalid = 1'b0;
		mem_bready = 1'b0;
		clint_arvalid = 1'b0;
		clint_rready = 1'b0;
		case (grant)
			grant_fetch: begin
				mem_arvalid = fetch_arvalid;
				fetch_arready = mem_arready;
				fetch_rvalid = mem_rvalid;
				mem_rready = fetch_rready;
			end
			grant_data_read: begin
				mem_arvalid = data_arvalid;
				data_arready = mem_arready;
				data_rvalid = mem_rvalid;
				mem_rready = data_rready;
			end
			grant_clint: begin
				clint_arvalid = data_arvalid;
				data_arready = clint_arready;
				data_rvalid = clint_rvalid;
				clint_rready = data_rready;
			end
			grant_data_write: begin
				if (clint_write) begin
					data_awready = local_accept;
					data_wready = local_accept;
					data_bvalid = local_bvalid;
				end else begin
					mem_awvalid = data_awvalid;
					data_awready = mem_awready;
					mem_wvalid = data_wvalid;
					data_wready = mem_wready;
					data_bvalid = mem_bvalid;
					mem_bready = data_bready;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
	input  logic clock,
	input  logic reset,

	input  logic clint_arvalid,
	input  axi_pkg::addr_t clint_araddr,
	input  axi_pkg::id_t clint_arid,
	output logic clint_arready,
	output logic clint_rvalid,
	output axi_pkg::data_t clint_rdata,
	output axi_pkg::resp_t clint_rresp,
	output axi_pkg::id_t clint_rid,
	input  logic clint_rready
);
	import axi_pkg::*;

	data_t mtime;
	logic ar_fire;
	logic hit_mtime;

	assign clint_arready = !clint_rvalid;
	assign ar_fire = clint_arvalid && clint_arready;

	// mtime sits in the first doubleword of the window, the rest reads as zero.
	assign hit_mtime = (clint_araddr[15:3] == 13'd0);

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			clint_rvalid <= 1'b0;
		end else if (ar_fire) begin
			clint_rvalid <= 1'b1;
		end else if (clint_rready) begin
			clint_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			clint_rdata <= hit_mtime ? mtime : '0; // value at the ar handshake.
			clint_rid <= clint_arid;
		end
	end

	assign clint_rresp = resp_okay;

endmodule

`default_nettype wire

// ==== axi_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_sram (
	input  logic clock,
	input  logic reset,

	input  logic mem_arvalid,
	input  axi_pkg::addr_t mem_araddr,
	input  axi_pkg::id_t mem_arid,
	output logic mem_arready,
	output logic mem_rvalid,
	output axi_pkg::data_t mem_rdata,
	output axi_pkg::resp_t mem_rresp,
	output axi_pkg::id_t mem_rid,
	output logic mem_rlast,
	input  logic mem_rready,

	input  logic mem_awvalid,
	input  axi_pkg::addr_t mem_awaddr,
	input  axi_pkg::id_t mem_awid,
	output logic mem_awready,
	input  logic mem_wvalid,
	input  axi_pkg::data_t mem_wdata,
	input  axi_pkg::strb_t mem_wstrb,
	output logic mem_wready,
	output logic mem_bvalid,
	output axi_pkg::resp_t mem_bresp,
	output axi_pkg::id_t mem_bid,
	input  logic mem_bready
);
	import axi_pkg::*;
	import soc_map_pkg::*;

	data_t mem [sram_words];
	logic [$clog2(sram_words)-1:0] rd_index;
	logic [$clog2(sram_words)-1:0] wr_index;
	logic ar_fire;
	logic wr_fire;

	// word index, bits 10 to 3 of the byte address.
	assign rd_index = mem_araddr[3 +: $clog2(sram_words)];
	assign wr_index = mem_awaddr[3 +: $clog2(sram_words)];

	assign mem_arready = !mem_rvalid;
	assign ar_fire = mem_arvalid && mem_arready;

	// address and data are taken together, once the last response is gone.
	assign wr_fire = mem_awvalid && mem_wvalid && !mem_bvalid;
	assign mem_awready = wr_fire;
	assign mem_wready = wr_fire;

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (mem_wstrb[i])
					mem[wr_index][8*i +: 8] <= mem_wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			mem_rdata <= mem[rd_index];
			mem_rid <= mem_arid;
		end
		if (wr_fire)
			mem_bid <= mem_awid;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_rvalid <= 1'b0;
		end else if (ar_fire) begin
			mem_rvalid <= 1'b1;
		end else if (mem_rready) begin
			mem_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_bvalid <= 1'b0;
		end else if (wr_fire) begin
			mem_bvalid <= 1'b1;
		end else if (mem_bready) begin
			mem_bvalid <= 1'b0;
		end
	end

	assign mem_rresp = resp_okay;
	assign mem_bresp = resp_okay;
	assign mem_rlast = 1'b1; // single beat only.

endmodule

`default_nettype wire

// ==== soc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	input  logic clock,
	input  logic reset,

	input  logic fetch_arvalid,
	input  axi_pkg::addr_t fetch_araddr,
	input  axi_pkg::id_t fetch_arid,
	output logic fetch_arready,
	output logic fetch_rvalid,
	output axi_pkg::data_t fetch_rdata,
	output axi_pkg::resp_t fetch_rresp,
	output axi_pkg::id_t fetch_rid,
	output logic fetch_rlast,
	input  logic fetch_rready,

	input  logic data_arvalid,
	input  axi_pkg::addr_t data_araddr,
	input  axi_pkg::id_t data_arid,
	output logic data_arready,
	output logic data_rvalid,
	output axi_pkg::data_t data_rdata,
	output axi_pkg::resp_t data_rresp,
	output axi_pkg::id_t data_rid,
	output logic data_rlast,
	input  logic data_rready,
	input  logic data_awvalid,
	input  axi_pkg::addr_t data_awaddr,
	input  axi_pkg::id_t data_awid,
	output logic data_awready,
	input  logic data_wvalid,
	input  axi_pkg::data_t data_wdata,
	input  axi_pkg::strb_t data_wstrb,
	output logic data_wready,
	output logic data_bvalid,
	output axi_pkg::resp_t data_bresp,
	output axi_pkg::id_t data_bid,
	input  logic data_bready
);
	import axi_pkg::*;

	// arbiter to sram.
	logic mem_arvalid;
	addr_t mem_araddr;
	id_t mem_arid;
	logic mem_arready;
	logic mem_rvalid;
	data_t mem_rdata;
	resp_t mem_rresp;
	id_t mem_rid;
	logic mem_rlast;
	logic mem_rready;
	logic mem_awvalid;
	addr_t mem_awaddr;
	id_t mem_awid;
	logic mem_awready;
	logic mem_wvalid;
	data_t mem_wdata;
	strb_t mem_wstrb;
	logic mem_wready;
	logic mem_bvalid;
	resp_t mem_bresp;
	id_t mem_bid;
	logic mem_bready;

	// arbiter to timer, read only.
	logic clint_arvalid;
	addr_t clint_araddr;
	id_t clint_arid;
	logic clint_arready;
	logic clint_rvalid;
	data_t clint_rdata;
	resp_t clint_rresp;
	id_t clint_rid;
	logic clint_rready;

	bus_arbiter u_arbiter (.*);

	axi_sram u_sram (.*);

	clint_timer u_clint (.*);

endmodule

`default_nettype wire

// ==== soc_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_checker (
	input  logic clock,
	input  logic reset,
	input  soc_map_pkg::grant_t grant,
	input  logic fetch_arvalid,
	input  logic fetch_arready,
	input  axi_pkg::addr_t fetch_araddr,
	input  logic fetch_rvalid,
	input  logic fetch_rready,
	input  logic data_arvalid,
	input  logic data_arready,
	input  axi_pkg::addr_t data_araddr,
	input  logic data_rvalid,
	input  logic data_rready,
	input  logic data_awvalid,
	input  logic data_awready,
	input  axi_pkg::addr_t data_awaddr,
	input  logic data_wvalid,
	input  logic data_wready,
	input  axi_pkg::data_t data_wdata,
	input  logic data_bvalid,
	input  logic data_bready
);
	import soc_map_pkg::*;

	int fail_count = 0;

	fetch_ar_held: assert property (@(posedge clock) disable iff (reset)
		fetch_arvalid && !fetch_arready |=> fetch_arvalid && $stable(fetch_araddr))
		else begin $error("fetch ar changed before ready."); fail_count++; end
	data_ar_held: assert property (@(posedge clock) disable iff (reset)
		data_arvalid && !data_arready |=> data_arvalid && $stable(data_araddr))
		else begin $error("data ar changed before ready."); fail_count++; end
	data_aw_held: assert property (@(posedge clock) disable iff (reset)
		data_awvalid && !data_awready |=> data_awvalid && $stable(data_awaddr))
		else begin $error("data aw changed before ready."); fail_count++; end
	data_w_held: assert property (@(posedge clock) disable iff (reset)
		data_wvalid && !data_wready |=> data_wvalid && $stable(data_wdata))
		else begin $error("data w changed before ready."); fail_count++; end
	fetch_r_held: assert property (@(posedge clock) disable iff (reset)
		fetch_rvalid && !fetch_rready |=> fetch_rvalid)
		else begin $error("fetch rvalid dropped before rready."); fail_count++; end
	data_r_held: assert property (@(posedge clock) disable iff (reset)
		data_rvalid && !data_rready |=> data_rvalid)
		else begin $error("data rvalid dropped before rready."); fail_count++; end
	data_b_held: assert property (@(posedge clock) disable iff (reset)
		data_bvalid && !data_bready |=> data_bvalid)
		else begin $error("data bvalid dropped before bready."); fail_count++; end

	// one master at most sees any handshake activity.
	one_master: assert property (@(posedge clock) disable iff (reset)
		$onehot0({fetch_arready || fetch_rvalid,
			data_arready || data_rvalid || data_awready || data_wready || data_bvalid}))
		else begin $error("both masters active at once."); fail_count++; end
	fetch_r_routed: assert property (@(posedge clock) disable iff (reset)
		fetch_rvalid |-> grant == grant_fetch)
		else begin $error("fetch rvalid without fetch grant."); fail_count++; end
	data_r_routed: assert property (@(posedge clock) disable iff (reset)
		data_rvalid |-> grant inside {grant_clint, grant_data_read})
		else begin $error("data rvalid without read grant."); fail_count++; end
	data_b_routed: assert property (@(posedge clock) disable iff (reset)
		data_bvalid |-> grant == grant_data_write)
		else begin $error("data bvalid without write grant."); fail_count++; end

endmodule

bind bus_arbiter soc_checker u_checker (
	.clock(clock), .reset(reset), .grant(grant),
	.fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
	.fetch_araddr(fetch_araddr), .fetch_rvalid(fetch_rvalid), .fetch_rready(fetch_rready),
	.data_arvalid(data_arvalid), .data_arready(data_arready), .data_araddr(data_araddr),
	.data_rvalid(data_rvalid), .data_rready(data_rready),
	.data_awvalid(data_awvalid), .data_awready(data_awready), .data_awaddr(data_awaddr),
	.data_wvalid(data_wvalid), .data_wready(data_wready), .data_wdata(data_wdata),
	.data_bvalid(data_bvalid), .data_bready(data_bready)
);

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top;
	import axi_pkg::*;
	import soc_map_pkg::*;

	localparam int max_txns = 40;
	localparam int txn_cycles = 50; // worst case for one transaction.
	localparam int timeout_cycles = max_txns * txn_cycles;
	localparam int reset_cycles = 10;
	localparam int num_addrs = 8;

	logic clock;
	logic reset;
	logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rlast, fetch_rready;
	addr_t fetch_araddr;
	id_t fetch_arid, fetch_rid;
	data_t fetch_rdata;
	resp_t fetch_rresp;
	logic data_arvalid, data_arready, data_rvalid, data_rlast, data_rready;
	addr_t data_araddr, data_awaddr;
	id_t data_arid, data_rid, data_awid, data_bid;
	data_t data_rdata, data_wdata;
	resp_t data_rresp, data_bresp;
	logic data_awvalid, data_awready, data_wvalid, data_wready, data_bvalid, data_bready;
	strb_t data_wstrb;

	logic [31:0] lfsr_state;
	data_t shadow [sram_words];
	addr_t test_addr [num_addrs];
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	soc_top dut (.*);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout: no end of test after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output data_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	task automatic check_equal(input string what, input data_t got, input data_t exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	task automatic write_word(input addr_t addr, input data_t wdata, input strb_t wstrb,
			input logic stall, output resp_t resp);
		id_t id;
		id = addr[6:3] ^ 4'h5;
		@(negedge clock);
		data_awvalid = 1'b1;
		data_awaddr = addr;
		data_awid = id;
		data_wvalid = 1'b1;
		data_wdata = wdata;
		data_wstrb = wstrb;
		data_bready = !stall;
		@(posedge clock);
		while (!(data_awready && data_wready)) @(posedge clock);
		@(negedge clock);
		data_awvalid = 1'b0;
		data_wvalid = 1'b0;
		@(posedge clock);
		while (!data_bvalid) @(posedge clock);
		if (stall) begin
			@(negedge clock); // response waits one cycle.
			data_bready = 1'b1;
			@(posedge clock);
			while (!data_bvalid) @(posedge clock);
		end
		resp = data_bresp;
		check_equal("write bid", data_t'(data_bid), data_t'(id));
		@(negedge clock);
		data_bready = 1'b0;
	endtask

	task automatic read_word(input logic from_fetch, input addr_t addr, input logic stall,
			output data_t rdata, output resp_t resp, output time done_at);
		id_t id;
		id = addr[6:3] ^ 4'ha;
		@(negedge clock);
		if (from_fetch) begin
			fetch_arvalid = 1'b1;
			fetch_araddr = addr;
			fetch_arid = id;
			fetch_rready = !stall;
		end else begin
			data_arvalid = 1'b1;
			data_araddr = addr;
			data_arid = id;
			data_rready = !stall;
		end
		@(posedge clock);
		while (!(from_fetch ? fetch_arready : data_arready)) @(posedge clock);
		@(negedge clock);
		if (from_fetch)
			fetch_arvalid = 1'b0;
		else
			data_arvalid = 1'b0;
		@(posedge clock);
		while (!(from_fetch ? fetch_rvalid : data_rvalid)) @(posedge clock);
		done_at = $time;
		if (stall) begin
			@(negedge clock); // response waits one cycle.
			if (from_fetch)
				fetch_rready = 1'b1;
			else
				data_rready = 1'b1;
			@(posedge clock);
			while (!(from_fetch ? fetch_rvalid : data_rvalid)) @(posedge clock);
		end
		rdata = from_fetch ? fetch_rdata : data_rdata;
		resp = from_fetch ? fetch_rresp : data_rresp;
		check_equal("read rid", data_t'(from_fetch ? fetch_rid : data_rid), data_t'(id));
		check_equal("read rlast", data_t'(from_fetch ? fetch_rlast : data_rlast), 64'd1);
		@(negedge clock);
		if (from_fetch)
			fetch_rready = 1'b0;
		else
			data_rready = 1'b0;
	endtask

	initial begin
		data_t value;
		data_t first;
		data_t merged;
		strb_t strobe;
		resp_t resp;
		time t_fetch;
		time t_data;
		data_t value_b;
		resp_t resp_b;
		int idx;
		int err_mark;

		{fetch_arvalid, fetch_rready, data_arvalid, data_rready} = '0;
		{data_awvalid, data_wvalid, data_bready} = '0;
		fetch_araddr = '0;
		fetch_arid = 4'h1;
		data_araddr = '0;
		data_arid = 4'h3;
		data_awaddr = '0;
		data_awid = '0;
		data_wdata = '0;
		data_wstrb = '0;
		lfsr_state = 32'hb113c76c;
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		err_mark = errors;
		repeat (4) begin
			@(negedge clock);
			check_equal("idle handshake outputs", data_t'({fetch_arready, fetch_rvalid,
				data_arready, data_rvalid, data_awready, data_wready, data_bvalid}), '0);
		end
		end_test("reset idle", err_mark);

		// full write first so every byte of the shadow is known.
		err_mark = errors;
		for (int i = 0; i < num_addrs; i++) begin
			idx = (i * 37 + 5) % sram_words;
			test_addr[i] = addr_t'(idx << 3);
			take_bits(64, value);
			write_word(test_addr[i], value, 8'hff, 1'b0, resp);
			check_equal("full write resp", data_t'(resp), data_t'(resp_okay));
			shadow[idx] = value;
			take_bits(64, value);
			take_bits(8, merged);
			strobe = merged[7:0];
			write_word(test_addr[i], value, strobe, (i % 2) == 1, resp);
			check_equal("strobe write resp", data_t'(resp), data_t'(resp_okay));
			for (int b = 0; b < 8; b++) begin
				if (strobe[b])
					shadow[idx][8*b +: 8] = value[8*b +: 8];
			end
		end
		for (int i = 0; i < num_addrs; i++) begin
			read_word(1'b0, test_addr[i], (i % 2) == 0, value, resp, t_data);
			check_equal("data read", value, shadow[test_addr[i][10:3]]);
			check_equal("data read resp", data_t'(resp), data_t'(resp_okay));
		end
		end_test("data write and read", err_mark);

		err_mark = errors;
		for (int i = 0; i < num_addrs; i++) begin
			read_word(1'b1, test_addr[i], (i % 2) == 1, value, resp, t_fetch);
			check_equal("fetch read", value, shadow[test_addr[i][10:3]]);
			check_equal("fetch read resp", data_t'(resp), data_t'(resp_okay));
		end
		end_test("fetch read", err_mark);

		err_mark = errors;
		read_word(1'b0, clint_base, 1'b1, first, resp, t_data);
		check_equal("mtime resp 1", data_t'(resp), data_t'(resp_okay));
		read_word(1'b0, clint_base, 1'b0, value, resp, t_data);
		check_equal("mtime resp 2", data_t'(resp), data_t'(resp_okay));
		check_equal("mtime increasing", data_t'(value > first), 64'd1);
		write_word(clint_base | test_addr[0], 64'hdead_beef_0bad_f00d, 8'hff, 1'b1, resp);
		check_equal("clint write resp", data_t'(resp), data_t'(resp_slverr));
		read_word(1'b0, test_addr[0], 1'b0, value, resp, t_data);
		check_equal("sram after clint write", value, shadow[test_addr[0][10:3]]);
		end_test("clint access", err_mark);

		err_mark = errors;
		fork
			read_word(1'b1, test_addr[2], 1'b0, value, resp, t_fetch);
			read_word(1'b0, test_addr[3], 1'b0, value_b, resp_b, t_data);
		join
		check_equal("contended fetch", value, shadow[test_addr[2][10:3]]);
		check_equal("contended fetch resp", data_t'(resp), data_t'(resp_okay));
		check_equal("contended data", value_b, shadow[test_addr[3][10:3]]);
		check_equal("contended data resp", data_t'(resp_b), data_t'(resp_okay));
		check_equal("fetch served first", data_t'(t_fetch < t_data), 64'd1);
		end_test("contended reads", err_mark);

		errors += dut.u_arbiter.u_checker.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
axi_pkg.sv
soc_map_pkg.sv
bus_arbiter.sv
clint_timer.sv
axi_sram.sv
soc_top.sv
soc_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_top
FILELIST = verilog.f
PASS_TEXT = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
